/* tb.f */
+incdir+.
cnn_geom_pkg.sv
cnn_stream_pkg.sv
pixel_bank_ram.sv
block_sequencer.sv
window_gather.sv
result_writeback.sv
conv_feed_top.sv
tb_conv_feed.sv

/* run.sh */
#!/bin/sh
# Build and run the feeder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_conv_feed -o tb_conv_feed_sim

out=$(./obj_dir/tb_conv_feed_sim 2>&1) || true
echo "$out"
echo "$out" | grep -q '^\*\*\* TEST PASSED \*\*\*$'

/* tb_feed_model.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Included inside tb_conv_feed, reads img_mem and prm_mem
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_FEED_MODEL_SVH
`define TB_FEED_MODEL_SVH

// Pixel (row, col) sits in bank {row parity, col parity}
function automatic bank_sel_t image_bank_of(int row, int col);
    return bank_sel_t'((row % 2) * 2 + (col % 2));
endfunction

function automatic bank_addr_t image_addr_of(int row, int col);
    return bank_addr_t'((row / 2) * IMG_QUADS + col / 2);
endfunction

function automatic bank_sel_t result_bank_of(int n);
    return bank_sel_t'(n % NUM_BANKS);
endfunction

function automatic res_addr_t result_addr_of(int n);
    return res_addr_t'(n / NUM_BANKS);
endfunction

// Tile pixel (i, j) of a block, blocks counted filter-major
function automatic pixel_t tile_pixel(int blk, int i, int j);
    int b;
    b = blk % BLOCKS_PER_FILTER;
    return img_mem[2 * (b / BLOCKS_PER_SIDE) + i][2 * (b % BLOCKS_PER_SIDE) + j];
endfunction

// Expected beat number 'beat' of block 'blk'
task automatic model_beat(input int blk, input int beat, output beat_kind_t kind,
                          output pixel_t p0, output pixel_t p1, output pixel_t p2,
                          output pixel_t p3, output pixel_t prm);
    int base;
    int i;
    int j;
    base = (blk / BLOCKS_PER_FILTER) * PARAMS_PER_FILTER;
    i    = (beat - 1) / 3;  // Taps row-major over a 3x3 grid
    j    = (beat - 1) % 3;
    p0   = '0;
    p1   = '0;
    p2   = '0;
    p3   = '0;
    if (beat == 0) begin
        kind = BEAT_BIAS;
        prm  = prm_mem[base];
    end else if (beat <= TAPS) begin
        kind = BEAT_TAP;
        p0   = tile_pixel(blk, i, j);
        p1   = tile_pixel(blk, i, j + 1);
        p2   = tile_pixel(blk, i + 1, j);
        p3   = tile_pixel(blk, i + 1, j + 1);
        prm  = prm_mem[base + beat];
    end else begin
        kind = BEAT_CMD;
        p0   = CMD_OPCODE;
        prm  = CMD_ARG;
    end
endtask

`endif

/* tb_conv_feed.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two full jobs on random data with engine stalls
// Stops at the first mismatch or on timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_conv_feed
    import cnn_geom_pkg::*;
    import cnn_stream_pkg::*;
();

    localparam int IMG_SIDE     = 2 * IMG_QUADS;
    localparam int TOTAL_BLOCKS = FILTERS * BLOCKS_PER_FILTER;
    localparam int TOTAL_BEATS  = TOTAL_BLOCKS * BEATS_PER_BLOCK;
    localparam int LOAD_CYCLES  = 20 + IMG_SIDE * IMG_SIDE + FILTERS * PARAMS_PER_FILTER;
    localparam int READ_CYCLES  = 3 * TOTAL_BLOCKS;
    // Two jobs at up to four cycles per beat plus loading and readback
    localparam int CYCLE_LIMIT  = 2 * (4 * TOTAL_BEATS + READ_CYCLES) + LOAD_CYCLES;

    logic         clk;
    logic         reset;
    logic         start_valid;
    logic         start_ready;
    logic         load_valid;
    load_target_t load_target;
    bank_sel_t    load_bank;
    bank_addr_t   load_addr;
    pixel_t       load_data;
    logic         feed_valid;
    logic         feed_ready;
    beat_kind_t   feed_kind;
    pixel_t       feed_pix0;
    pixel_t       feed_pix1;
    pixel_t       feed_pix2;
    pixel_t       feed_pix3;
    pixel_t       feed_param;
    logic         result_valid;
    logic         result_ready;
    pixel_t       result_data;
    bank_sel_t    rd_bank;
    res_addr_t    rd_addr;
    pixel_t       rd_data;
    logic         done;

    pixel_t      img_mem [IMG_SIDE][IMG_SIDE];
    pixel_t      prm_mem [FILTERS * PARAMS_PER_FILTER];
    pixel_t      sent_res [TOTAL_BLOCKS];   // What the engine returned, by index
    pixel_t      pending [$];               // Engine results not yet offered
    int unsigned pix_sum [4];
    int          seed;
    int          cycles;
    int          beat_no;
    int          res_sent;
    int          delay_cnt;
    logic        res_taken;
    string       test_name;

    `include "tb_feed_model.svh"

    conv_feed_top dut0 (.*);

    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped");
    endtask

    task automatic check_beat(input string name, input beat_kind_t exp_kind,
                              input pixel_t e0, e1, e2, e3, ep,
                              input beat_kind_t act_kind,
                              input pixel_t a0, a1, a2, a3, ap);
        if (exp_kind !== act_kind || {e0, e1, e2, e3, ep} !== {a0, a1, a2, a3, ap}) begin
            abort_run({$sformatf("Error %s: expected %s %h %h %h %h param %h, ", name,
                                 exp_kind.name(), e0, e1, e2, e3, ep),
                       $sformatf("got %s %h %h %h %h param %h", act_kind.name(),
                                 a0, a1, a2, a3, ap)});
        end
    endtask

    task automatic check_result(input string name, input pixel_t exp, input pixel_t act);
        if (exp !== act)
            abort_run($sformatf("Error %s: expected %h, got %h", name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act)
            abort_run($sformatf("Error %s: expected %b, got %b", name, exp, act));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act)
            abort_run($sformatf("Error %s: expected %0d, got %0d", name, exp, act));
    endtask

    // Engine pools by taking the largest per-position sum over the taps
    function automatic pixel_t engine_result();
        int unsigned best;
        best = pix_sum[0];
        for (int k = 1; k < 4; k++) begin
            if (pix_sum[k] > best) best = pix_sum[k];
        end
        return pixel_t'(best);
    endfunction

    // Handshakes sampled mid-cycle where every signal is settled
    always @(negedge clk) begin
        beat_kind_t ek;
        pixel_t     e0, e1, e2, e3, ep;
        int         blk;
        int         beat;
        res_taken = result_valid && result_ready;
        if (feed_valid && feed_ready) begin
            if (beat_no >= TOTAL_BEATS) abort_run("DUT sent more beats than one job holds");
            blk  = beat_no / BEATS_PER_BLOCK;
            beat = beat_no % BEATS_PER_BLOCK;
            model_beat(blk, beat, ek, e0, e1, e2, e3, ep);
            check_beat($sformatf("%s block %0d beat %0d", test_name, blk, beat), ek,
                       e0, e1, e2, e3, ep, feed_kind,
                       feed_pix0, feed_pix1, feed_pix2, feed_pix3, feed_param);
            if (feed_kind == BEAT_TAP) begin
                pix_sum[0] += feed_pix0;
                pix_sum[1] += feed_pix1;
                pix_sum[2] += feed_pix2;
                pix_sum[3] += feed_pix3;
            end else if (feed_kind == BEAT_CMD) begin
                pending.push_back(engine_result());
                for (int k = 0; k < 4; k++) pix_sum[k] = 0;
            end
            beat_no++;
        end
        if (res_taken) begin
            if (res_sent >= TOTAL_BLOCKS) abort_run("DUT accepted more results than blocks");
            sent_res[res_sent] = result_data;
            res_sent++;
        end
    end

    // Engine side stalls at random only while a job is active
    always @(posedge clk) begin
        #1;
        if (result_ready) feed_ready = ({$random(seed)} % 10) >= 3;
        else              feed_ready = 1'b1;
        if (res_taken) result_valid = 1'b0;
        if (!result_valid && pending.size() > 0) begin
            if (delay_cnt == 0) begin
                result_valid = 1'b1;
                result_data  = pending.pop_front();
                delay_cnt    = {$random(seed)} % 4;
            end else begin
                delay_cnt--;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) abort_run("timeout, the job did not finish in time");
    end

    task automatic load_word(input load_target_t target, input bank_sel_t bank,
                             input bank_addr_t addr, input pixel_t data);
        load_valid  = 1'b1;
        load_target = target;
        load_bank   = bank;
        load_addr   = addr;
        load_data   = data;
        @(posedge clk);
        #1;
        load_valid  = 1'b0;
    endtask

    task automatic fill_memories();
        for (int r = 0; r < IMG_SIDE; r++) begin
            for (int c = 0; c < IMG_SIDE; c++) begin
                img_mem[r][c] = pixel_t'($random(seed));
                load_word(LOAD_IMAGE, image_bank_of(r, c), image_addr_of(r, c), img_mem[r][c]);
            end
        end
        for (int k = 0; k < FILTERS * PARAMS_PER_FILTER; k++) begin
            prm_mem[k] = pixel_t'($random(seed));
            load_word(LOAD_PARAM, '0, bank_addr_t'(k), prm_mem[k]);
        end
    endtask

    task automatic run_job(input string name);
        test_name   = name;
        beat_no     = 0;
        res_sent    = 0;
        start_valid = 1'b1;
        do @(negedge clk); while (!start_ready);
        @(posedge clk);
        #1;
        start_valid = 1'b0;
        check_flag({name, " done cleared"}, 1'b0, done);
        check_flag({name, " result_ready during job"}, 1'b1, result_ready);
        do @(negedge clk); while (!done);
        @(posedge clk);
        #1;
        check_flag({name, " result_ready after done"}, 1'b0, result_ready);
        check_count({name, " beat count"}, TOTAL_BEATS, beat_no);
        check_count({name, " result count"}, TOTAL_BLOCKS, res_sent);
        check_count({name, " results left in engine"}, 0, pending.size());
    endtask

    // Readback latency is one cycle
    task automatic read_results();
        for (int n = 0; n < TOTAL_BLOCKS; n++) begin
            rd_bank = result_bank_of(n);
            rd_addr = result_addr_of(n);
            @(posedge clk);
            @(negedge clk);
            check_result($sformatf("%s result %0d", test_name, n), sent_res[n], rd_data);
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        seed         = 32'h636e;
        cycles       = 0;
        delay_cnt    = 0;
        res_taken    = 1'b0;
        clk          = 1'b0;
        reset        = 1'b1;
        start_valid  = 1'b0;
        load_valid   = 1'b0;
        load_target  = LOAD_IMAGE;
        load_bank    = '0;
        load_addr    = '0;
        load_data    = '0;
        feed_ready   = 1'b0;
        result_valid = 1'b0;
        result_data  = '0;
        rd_bank      = '0;
        rd_addr      = '0;
        for (int k = 0; k < 4; k++) pix_sum[k] = 0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        check_flag("reset start_ready", 1'b1, start_ready);
        check_flag("reset feed_valid", 1'b0, feed_valid);
        check_flag("reset done", 1'b0, done);

        fill_memories();
        run_job("job 1");
        read_results();
        run_job("job 2");  // Same stream, results rewritten from index 0
        read_results();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* conv_feed_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load port is only legal while start_ready is high
// Result readback data arrives one cycle after rd_addr
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module conv_feed_top
    import cnn_geom_pkg::*;
    import cnn_stream_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         start_valid,
    output logic         start_ready,
    input  logic         load_valid,
    input  load_target_t load_target,
    input  bank_sel_t    load_bank,
    input  bank_addr_t   load_addr,
    input  pixel_t       load_data,
    output logic         feed_valid,
    input  logic         feed_ready,
    output beat_kind_t   feed_kind,
    output pixel_t       feed_pix0,
    output pixel_t       feed_pix1,
    output pixel_t       feed_pix2,
    output pixel_t       feed_pix3,
    output pixel_t       feed_param,
    input  logic         result_valid,
    output logic         result_ready,
    input  pixel_t       result_data,
    input  bank_sel_t    rd_bank,
    input  res_addr_t    rd_addr,
    output pixel_t       rd_data,
    output logic         done
);

    pixel_t      img_rdata [NUM_BANKS];
    pixel_t      res_rdata [NUM_BANKS];
    pixel_t      param_rdata;
    bank_addr_t  img_addr;
    bank_addr_t  img_ram_addr;
    param_addr_t param_addr;
    param_addr_t param_ram_addr;
    logic        slot_valid;
    logic [3:0]  slot_index;
    logic        buf_free;
    logic        job_start;
    logic [3:0]  res_we;
    res_addr_t   res_addr;
    pixel_t      res_wdata;
    bank_sel_t   rd_bank_q;

    // Loader owns the read-side RAMs while idle
    assign img_ram_addr   = load_valid ? load_addr : img_addr;
    assign param_ram_addr = load_valid ? load_addr[PARAM_ADDR_W-1:0] : param_addr;

    block_sequencer u_seq (
        .clk, .reset, .start_valid, .start_ready, .slot_valid, .slot_index,
        .img_addr, .param_addr, .buf_free, .job_start
    );

    window_gather u_gather (
        .clk, .reset, .slot_valid, .slot_index,
        .bank_rdata0(img_rdata[0]), .bank_rdata1(img_rdata[1]),
        .bank_rdata2(img_rdata[2]), .bank_rdata3(img_rdata[3]),
        .param_rdata, .buf_free, .feed_valid, .feed_ready, .feed_kind,
        .feed_pix0, .feed_pix1, .feed_pix2, .feed_pix3, .feed_param
    );

    result_writeback u_wb (
        .clk, .reset, .job_start, .result_valid, .result_ready, .result_data,
        .res_we, .res_addr, .res_wdata, .done
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_img
        pixel_bank_ram #(.DEPTH(IMG_QUADS * IMG_QUADS), .ADDR_W(BANK_ADDR_W)) u_ram (
            .clk, .addr(img_ram_addr), .wdata(load_data),
            .we(load_valid && load_target == LOAD_IMAGE && load_bank == bank_sel_t'(b)),
            .rdata(img_rdata[b])
        );
    end

    pixel_bank_ram #(.DEPTH(FILTERS * PARAMS_PER_FILTER), .ADDR_W(PARAM_ADDR_W)) u_param (
        .clk, .addr(param_ram_addr), .wdata(load_data),
        .we(load_valid && load_target == LOAD_PARAM), .rdata(param_rdata)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_res
        pixel_bank_ram #(.DEPTH(FILTERS * BLOCKS_PER_FILTER / NUM_BANKS),
                         .ADDR_W(RES_ADDR_W)) u_ram (
            .clk, .addr(res_we[b] ? res_addr : rd_addr), .wdata(res_wdata),
            .we(res_we[b]), .rdata(res_rdata[b])
        );
    end

    // Bank select follows the RAM latency
    always_ff @(posedge clk) rd_bank_q <= rd_bank;
    assign rd_data = res_rdata[rd_bank_q];

    a_load_idle: assert property (@(posedge clk) disable iff (reset)
        load_valid |-> start_ready)
        else $error("load attempted during a job");

endmodule

/* result_writeback.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result n goes to bank n mod 4, address n div 4
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module result_writeback
    import cnn_geom_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       job_start,
    input  logic       result_valid,
    output logic       result_ready,
    input  pixel_t     result_data,
    output logic [3:0] res_we,
    output res_addr_t  res_addr,
    output pixel_t     res_wdata,
    output logic       done
);

    logic [RES_ADDR_W+1:0] res_cnt;
    logic                  active;
    logic                  last_q;   // Final write in flight
    logic                  accept;

    assign result_ready = active;
    assign accept       = result_valid && result_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            res_cnt <= '0;
            active  <= 1'b0;
            last_q  <= 1'b0;
            res_we  <= '0;
            done    <= 1'b0;
        end else begin
            res_we <= '0;
            last_q <= 1'b0;
            if (last_q) done <= 1'b1;
            if (job_start) begin
                res_cnt <= '0;
                active  <= 1'b1;
                done    <= 1'b0;
            end else if (accept) begin
                res_we  <= 4'b0001 << res_cnt[1:0];
                res_cnt <= res_cnt + 1'b1;
                if (res_cnt == (RES_ADDR_W + 2)'(FILTERS * BLOCKS_PER_FILTER - 1)) begin
                    active <= 1'b0;
                    last_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            res_addr  <= res_cnt[RES_ADDR_W+1:2];
            res_wdata <= result_data;
        end
    end

    // Writes stay inside the result banks once the job total is reached
    a_res_in_range: assert property (@(posedge clk) disable iff (reset)
        (res_we != '0) |-> res_addr < RES_ADDR_W'(FILTERS * BLOCKS_PER_FILTER / NUM_BANKS))
        else $error("result write past the end of the result banks");

endmodule

/* window_gather.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two tile buffers, one fills while one streams
// Slot data is expected one cycle after the slot
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module window_gather
    import cnn_geom_pkg::*;
    import cnn_stream_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       slot_valid,
    input  logic [3:0] slot_index,
    input  pixel_t     bank_rdata0,
    input  pixel_t     bank_rdata1,
    input  pixel_t     bank_rdata2,
    input  pixel_t     bank_rdata3,
    input  pixel_t     param_rdata,
    output logic       buf_free,
    output logic       feed_valid,
    input  logic       feed_ready,
    output beat_kind_t feed_kind,
    output pixel_t     feed_pix0,
    output pixel_t     feed_pix1,
    output pixel_t     feed_pix2,
    output pixel_t     feed_pix3,
    output pixel_t     feed_param
);

    pixel_t     tile [2][16];                 // 4x4 row-major
    pixel_t     prm  [2][PARAMS_PER_FILTER];
    pixel_t     bank_rd [4];
    logic [1:0] full;
    logic [1:0] claimed;                      // Buffers owned by fill or emit
    logic       wr_sel;
    logic       rd_sel;
    logic       slot_d_valid;
    logic [3:0] slot_d_index;
    logic [3:0] beat_cnt;
    logic [3:0] tap;
    logic [3:0] tap_base;
    logic       claim;
    logic       release_buf;

    assign bank_rd[0] = bank_rdata0;
    assign bank_rd[1] = bank_rdata1;
    assign bank_rd[2] = bank_rdata2;
    assign bank_rd[3] = bank_rdata3;

    assign claim       = slot_valid && (slot_index == 4'd0);
    assign release_buf = feed_valid && feed_ready && (beat_cnt == 4'(BEATS_PER_BLOCK - 1));
    assign buf_free    = (claimed < 2'd2);
    assign feed_valid  = full[rd_sel];

    // Align slot with RAM read data
    always_ff @(posedge clk) begin
        if (reset) slot_d_valid <= 1'b0;
        else       slot_d_valid <= slot_valid;
        slot_d_index <= slot_index;
    end

    // Tile index bits are {quad row, bank row, quad col, bank col}
    always_ff @(posedge clk) begin
        if (slot_d_valid) begin
            if (slot_d_index < 4'd4) begin
                for (int b = 0; b < 4; b++) begin
                    tile[wr_sel][{slot_d_index[1], b[1], slot_d_index[0], b[0]}] <= bank_rd[b];
                end
            end else begin
                prm[wr_sel][slot_d_index - 4'd4] <= param_rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            full     <= '0;
            claimed  <= '0;
            wr_sel   <= 1'b0;
            rd_sel   <= 1'b0;
            beat_cnt <= '0;
        end else begin
            claimed <= claimed + 2'(claim) - 2'(release_buf);
            if (slot_d_valid && slot_d_index == 4'(SLOTS_PER_BLOCK - 1)) begin
                full[wr_sel] <= 1'b1;  // Last parameter landed
                wr_sel       <= ~wr_sel;
            end
            if (feed_valid && feed_ready) begin
                if (release_buf) begin
                    beat_cnt     <= '0;
                    full[rd_sel] <= 1'b0;
                    rd_sel       <= ~rd_sel;
                end else begin
                    beat_cnt <= beat_cnt + 4'd1;
                end
            end
        end
    end

    // Tap (i, j) starts at tile index 4i + j
    assign tap      = beat_cnt - 4'd1;
    assign tap_base = 4'((tap / 4'd3) * 4'd4 + (tap % 4'd3));

    always_comb begin
        feed_kind  = BEAT_TAP;
        feed_pix0  = tile[rd_sel][tap_base];
        feed_pix1  = tile[rd_sel][tap_base + 4'd1];
        feed_pix2  = tile[rd_sel][tap_base + 4'd4];
        feed_pix3  = tile[rd_sel][tap_base + 4'd5];
        feed_param = prm[rd_sel][beat_cnt];
        if (beat_cnt == 4'd0) begin
            feed_kind = BEAT_BIAS;  // Bias, no pixels
            feed_pix0 = '0;
            feed_pix1 = '0;
            feed_pix2 = '0;
            feed_pix3 = '0;
        end else if (beat_cnt > 4'(TAPS)) begin
            feed_kind  = BEAT_CMD;
            feed_pix0  = CMD_OPCODE;
            feed_pix1  = '0;
            feed_pix2  = '0;
            feed_pix3  = '0;
            feed_param = CMD_ARG;
        end
    end

    a_feed_stable: assert property (@(posedge clk) disable iff (reset)
        feed_valid && !feed_ready |=> feed_valid &&
            $stable({feed_kind, feed_pix0, feed_pix1, feed_pix2, feed_pix3, feed_param}))
        else $error("feed payload changed while stalled");

endmodule

/* block_sequencer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Blocks run filter, quad row, quad column order
// A block's 14 slots go out back to back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module block_sequencer
    import cnn_geom_pkg::*;
    import cnn_stream_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start_valid,
    output logic        start_ready,
    output logic        slot_valid,
    output logic [3:0]  slot_index,
    output bank_addr_t  img_addr,
    output param_addr_t param_addr,
    input  logic        buf_free,
    output logic        job_start
);

    seq_state_t state;
    logic [1:0] filt_cnt;
    logic [3:0] qr_cnt;
    logic [3:0] qc_cnt;
    logic [3:0] slot_cnt;
    logic       last_slot;
    logic       last_col;
    logic       last_row;
    logic       last_filt;

    assign start_ready = (state == SEQ_IDLE);
    assign job_start   = start_valid && start_ready;
    assign slot_valid  = (state == SEQ_ISSUE);
    assign slot_index  = slot_cnt;

    assign last_slot = (slot_cnt == 4'(SLOTS_PER_BLOCK - 1));
    assign last_col  = (qc_cnt == 4'(BLOCKS_PER_SIDE - 1));
    assign last_row  = (qr_cnt == 4'(BLOCKS_PER_SIDE - 1));
    assign last_filt = (filt_cnt == 2'(FILTERS - 1));

    // Tile slot k reads the quad at (qr + k[1], qc + k[0])
    assign img_addr = bank_addr_t'(qr_cnt * IMG_QUADS + qc_cnt
                                   + (slot_cnt[1] ? IMG_QUADS : 0) + slot_cnt[0]);

    // Slots 4..13 walk the filter's bias and weights
    assign param_addr = (slot_cnt < 4'd4) ? '0 :
                        param_addr_t'(filt_cnt * PARAMS_PER_FILTER + slot_cnt - 4);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= SEQ_IDLE;
            filt_cnt <= '0;
            qr_cnt   <= '0;
            qc_cnt   <= '0;
            slot_cnt <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (start_valid) begin
                        filt_cnt <= '0;
                        qr_cnt   <= '0;
                        qc_cnt   <= '0;
                        slot_cnt <= '0;
                        state    <= SEQ_WAIT;
                    end
                end
                SEQ_WAIT: begin
                    if (buf_free) state <= SEQ_ISSUE;  // Gather has room for a block
                end
                SEQ_ISSUE: begin
                    if (last_slot) begin
                        slot_cnt <= '0;
                        if (last_col) begin
                            qc_cnt <= '0;
                            if (last_row) begin
                                qr_cnt   <= '0;
                                filt_cnt <= filt_cnt + 2'd1;
                            end else begin
                                qr_cnt <= qr_cnt + 4'd1;
                            end
                        end else begin
                            qc_cnt <= qc_cnt + 4'd1;
                        end
                        // Whole job issued
                        state <= (last_col && last_row && last_filt) ? SEQ_IDLE : SEQ_WAIT;
                    end else begin
                        slot_cnt <= slot_cnt + 4'd1;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // Gather must still have room when the first slot of a block goes out
    a_block_needs_buffer: assert property (@(posedge clk) disable iff (reset)
        slot_valid && (slot_cnt == 4'd0) |-> buf_free)
        else $error("block issued while gather had no free buffer");

endmodule

/* pixel_bank_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single port, read data one cycle after address
// Read during write returns the old word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module pixel_bank_ram
    import cnn_geom_pkg::*;
#(
    parameter int DEPTH  = 256,
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic [ADDR_W-1:0] addr,
    input  pixel_t            wdata,
    input  logic              we,
    output pixel_t            rdata
);

    pixel_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];  // Registered read
    end

endmodule

/* cnn_stream_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Beat stream and control encodings for the feeder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cnn_stream_pkg;

    typedef enum logic [1:0] {
        BEAT_BIAS,
        BEAT_TAP,
        BEAT_CMD
    } beat_kind_t;

    typedef enum logic {
        LOAD_IMAGE,
        LOAD_PARAM
    } load_target_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_WAIT
    } seq_state_t;

    // Pooling command sent after the last tap
    localparam logic [7:0] CMD_OPCODE = 8'hC1;
    localparam logic [7:0] CMD_ARG    = 8'h28;

    localparam int TAPS            = 9;
    localparam int BEATS_PER_BLOCK = TAPS + 2;  // Bias, taps, command
    localparam int SLOTS_PER_BLOCK = 14;        // 4 tile reads then 10 param reads

endpackage

/* cnn_geom_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 26x26 image held as 13x13 quads over four banks
// Address widths are sized for two filters only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cnn_geom_pkg;

    // Image and block geometry
    localparam int IMG_QUADS         = 13;            // Quads per row and per column
    localparam int BLOCKS_PER_SIDE   = IMG_QUADS - 1; // 4x4 blocks step one quad
    localparam int BLOCKS_PER_FILTER = 144;
    localparam int FILTERS           = 2;
    localparam int PARAMS_PER_FILTER = 10;            // Bias then nine weights

    // Memory layout
    localparam int NUM_BANKS    = 4;
    localparam int BANK_ADDR_W  = 8;
    localparam int PARAM_ADDR_W = 5;
    localparam int RES_ADDR_W   = 7;

    typedef logic [7:0] pixel_t;   // Pixel or weight

    typedef logic [BANK_ADDR_W-1:0]  bank_addr_t;
    typedef logic [PARAM_ADDR_W-1:0] param_addr_t;
    typedef logic [RES_ADDR_W-1:0]   res_addr_t;

    // Bank index, bit 1 is row parity and bit 0 column parity
    typedef logic [1:0] bank_sel_t;

endpackage
